/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dcache_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

/* common/dcache_pkg.sv */
package dcache_pkg;

	//////////////////////////////////////////////////////////////////////
	// Geometry
	//////////////////////////////////////////////////////////////////////

	// Word and address field widths
	localparam int WORD_W = 32;
	localparam int TAG_W  = 26;
	localparam int IDX_W  = 3;
	localparam int N_SETS = 8;

	typedef logic [WORD_W-1:0] word_t;

	// Byte address as the cache sees it
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             blkoff;
		logic [1:0]       byteoff;
	} addr_fields_t;

	// One way of one set
	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
		word_t            word0;
		word_t            word1;
	} cache_line_t;

	//////////////////////////////////////////////////////////////////////
	// Requests and internal commands
	//////////////////////////////////////////////////////////////////////

	// Processor request, held until hit
	typedef struct packed {
		logic         ren;
		logic         wen;
		addr_fields_t addr;
		word_t        store;
	} cpu_req_t;

	// Memory request, held while wait is high
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	// Line offered to the controller for write back
	typedef struct packed {
		logic             dirty;
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             way;
		word_t            word0;
		word_t            word1;
	} victim_t;

	typedef enum logic [1:0] {
		ARR_NONE,
		ARR_FILL,
		ARR_CLEAN
	} array_op_e;

	// Word selects which half of the block a fill lands in
	typedef struct packed {
		array_op_e op;
		logic      word;
	} array_cmd_t;

	typedef enum logic [3:0] {
		IDLE,
		WB0,
		WB1,
		FETCH0,
		FETCH1,
		FLUSH_SCAN,
		FLUSH_WB0,
		FLUSH_WB1,
		FLUSHED
	} ctrl_state_e;

endpackage

/* dcache/dcache_array.sv */
`timescale 1ns/1ps

module dcache_array (
	input  logic                   CLK,
	input  logic                   nRST,
	input  dcache_pkg::cpu_req_t   cpu_req,
	input  dcache_pkg::array_cmd_t array_cmd,
	input  logic                   flushing,
	input  dcache_pkg::word_t      mem_load,
	output logic                   hit,
	output dcache_pkg::word_t      load,
	output dcache_pkg::victim_t    victim
);

	import dcache_pkg::*;

	// Status bits per set, bit n belongs to way n
	logic [1:0]        valid_q [N_SETS];
	logic [1:0]        dirty_q [N_SETS];
	// Per set, the way to replace next
	logic [N_SETS-1:0] lru_q;

	// Tag and data storage
	logic [TAG_W-1:0]  tag_q  [N_SETS][2];
	word_t             data_q [N_SETS][2][2];

	// Both ways of the requested set
	cache_line_t       req_line [2];
	logic [IDX_W-1:0]  req_idx;
	logic              req_active;
	logic [1:0]        way_hit;
	logic              hit_way;
	logic              fill_way;

	// Selected write-back candidate
	logic [IDX_W-1:0]  vic_idx;
	logic              vic_way;
	logic              vic_dirty;

	//////////////////////////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////////////////////////

	assign req_idx    = cpu_req.addr.idx;
	assign req_active = cpu_req.ren || cpu_req.wen;
	// Misses and fills always go to the LRU way
	assign fill_way   = lru_q[req_idx];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			req_line[w].valid = valid_q[req_idx][w];
			req_line[w].dirty = dirty_q[req_idx][w];
			req_line[w].tag   = tag_q[req_idx][w];
			req_line[w].word0 = data_q[req_idx][w][0];
			req_line[w].word1 = data_q[req_idx][w][1];
			// Tag compare only counts for a live request
			way_hit[w] = req_active && req_line[w].valid &&
				(req_line[w].tag == cpu_req.addr.tag);
		end
	end

	assign hit     = |way_hit;
	// At most one way matches, so bit 1 names the way
	assign hit_way = way_hit[1];

	// Read data of the matching way
	assign load = cpu_req.addr.blkoff ? req_line[hit_way].word1 : req_line[hit_way].word0;

	//////////////////////////////////////////////////////////////////////
	// Victim select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Normal operation offers the LRU way of the request
		vic_idx   = req_idx;
		vic_way   = fill_way;
		vic_dirty = req_line[fill_way].dirty;
		if (flushing) begin
			vic_idx   = '0;
			vic_way   = 1'b0;
			vic_dirty = 1'b0;
			// Scan downward so the lowest dirty line wins
			for (int s = N_SETS - 1; s >= 0; s--) begin
				for (int w = 1; w >= 0; w--) begin
					if (dirty_q[s][w]) begin
						vic_idx   = IDX_W'(s);
						vic_way   = 1'(w);
						vic_dirty = 1'b1;
					end
				end
			end
		end
	end

	assign victim.dirty = vic_dirty;
	assign victim.tag   = tag_q[vic_idx][vic_way];
	assign victim.idx   = vic_idx;
	assign victim.way   = vic_way;
	assign victim.word0 = data_q[vic_idx][vic_way][0];
	assign victim.word1 = data_q[vic_idx][vic_way][1];

	//////////////////////////////////////////////////////////////////////
	// Updates
	//////////////////////////////////////////////////////////////////////

	// Valid, dirty and LRU state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < N_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
			lru_q <= '0;
		end else begin
			if (hit) begin
				// Point LRU at the way that was not touched
				lru_q[req_idx] <= ~hit_way;
				if (cpu_req.wen) begin
					dirty_q[req_idx][hit_way] <= 1'b1;
				end
			end
			case (array_cmd.op)
				ARR_FILL: begin
					// Line turns valid only once the second word is in
					valid_q[req_idx][fill_way] <= array_cmd.word;
					dirty_q[req_idx][fill_way] <= 1'b0;
				end
				ARR_CLEAN: begin
					dirty_q[vic_idx][vic_way] <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

	// Tag and data words
	always_ff @(posedge CLK) begin
		if (hit && cpu_req.wen) begin
			data_q[req_idx][hit_way][cpu_req.addr.blkoff] <= cpu_req.store;
		end
		if (array_cmd.op == ARR_FILL) begin
			tag_q[req_idx][fill_way]                  <= cpu_req.addr.tag;
			data_q[req_idx][fill_way][array_cmd.word] <= mem_load;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Fills and LRU must never leave one tag in both ways
	a_single_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
		!(way_hit[0] && way_hit[1]));

	// Flush only cleans and never refills
	a_no_fill_in_flush: assert property (@(posedge CLK) disable iff (!nRST)
		(array_cmd.op == ARR_FILL) |-> !flushing);

endmodule

/* dcache/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                   CLK,
	input  logic                   nRST,
	input  dcache_pkg::cpu_req_t   cpu_req,
	input  logic                   halt,
	input  logic                   hit,
	input  dcache_pkg::victim_t    victim,
	input  logic                   mem_wait,
	output dcache_pkg::array_cmd_t array_cmd,
	output logic                   flushing,
	output dcache_pkg::mem_req_t   mem_req,
	output logic                   flushed
);

	import dcache_pkg::*;

	ctrl_state_e  state;
	ctrl_state_e  next_state;

	// Request needs memory
	logic         miss;

	// Block addresses for write back and fetch
	addr_fields_t wb_addr;
	addr_fields_t fetch_addr;

	assign miss = (cpu_req.ren || cpu_req.wen) && !hit;

	//////////////////////////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Stay put while memory holds us off
		next_state = state;
		case (state)
			IDLE: begin
				if (miss) begin
					// Dirty LRU way goes out before the refill
					next_state = victim.dirty ? WB0 : FETCH0;
				end else if (halt) begin
					next_state = FLUSH_SCAN;
				end
			end
			WB0: begin
				if (!mem_wait) begin
					next_state = WB1;
				end
			end
			WB1: begin
				if (!mem_wait) begin
					next_state = FETCH0;
				end
			end
			FETCH0: begin
				if (!mem_wait) begin
					next_state = FETCH1;
				end
			end
			FETCH1: begin
				// Back to IDLE where the held request now hits
				if (!mem_wait) begin
					next_state = IDLE;
				end
			end
			FLUSH_SCAN: begin
				// Victim here is the lowest dirty line
				next_state = victim.dirty ? FLUSH_WB0 : FLUSHED;
			end
			FLUSH_WB0: begin
				if (!mem_wait) begin
					next_state = FLUSH_WB1;
				end
			end
			FLUSH_WB1: begin
				if (!mem_wait) begin
					next_state = FLUSH_SCAN;
				end
			end
			// Held until reset
			FLUSHED: begin
				next_state = FLUSHED;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Memory requests and array commands
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		mem_req   = '0;
		array_cmd = '{op: ARR_NONE, word: 1'b0};

		// Victim block base
		wb_addr = '{tag: victim.tag, idx: victim.idx, blkoff: 1'b0, byteoff: 2'b00};
		// Requested block base
		fetch_addr = cpu_req.addr;
		fetch_addr.blkoff  = 1'b0;
		fetch_addr.byteoff = 2'b00;

		case (state)
			WB0, FLUSH_WB0: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = word_t'(wb_addr);
				mem_req.store = victim.word0;
			end
			WB1, FLUSH_WB1: begin
				wb_addr.blkoff = 1'b1;
				mem_req.wen    = 1'b1;
				mem_req.addr   = word_t'(wb_addr);
				mem_req.store  = victim.word1;
				// Line is clean once the last word is accepted
				if (!mem_wait) begin
					array_cmd.op = ARR_CLEAN;
				end
			end
			FETCH0: begin
				mem_req.ren  = 1'b1;
				mem_req.addr = word_t'(fetch_addr);
				if (!mem_wait) begin
					array_cmd = '{op: ARR_FILL, word: 1'b0};
				end
			end
			FETCH1: begin
				fetch_addr.blkoff = 1'b1;
				mem_req.ren       = 1'b1;
				mem_req.addr      = word_t'(fetch_addr);
				if (!mem_wait) begin
					array_cmd = '{op: ARR_FILL, word: 1'b1};
				end
			end
			default: begin
			end
		endcase
	end

	// Array switches its victim to the dirty scan
	assign flushing = (state == FLUSH_SCAN) || (state == FLUSH_WB0) ||
		(state == FLUSH_WB1) || (state == FLUSHED);

	assign flushed = (state == FLUSHED);

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_one_mem_op: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen));

	// Victim and request must not move under a stalled access
	a_mem_req_held: assert property (@(posedge CLK) disable iff (!nRST)
		((mem_req.ren || mem_req.wen) && mem_wait) |=> $stable(mem_req));

endmodule

/* dcache/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input  logic                 CLK,
	input  logic                 nRST,
	// Processor side
	input  dcache_pkg::cpu_req_t cpu_req,
	input  logic                 halt,
	output logic                 hit,
	output dcache_pkg::word_t    load,
	output logic                 flushed,
	// Memory side
	output dcache_pkg::mem_req_t mem_req,
	input  logic                 mem_wait,
	input  dcache_pkg::word_t    mem_load
);

	import dcache_pkg::*;

	// Controller to array
	array_cmd_t array_cmd;
	logic       flushing;

	// Array to controller
	victim_t    victim;

	// Tag and data store with hit logic and LRU
	dcache_array u_array (
		.CLK       (CLK),
		.nRST      (nRST),
		.cpu_req   (cpu_req),
		.array_cmd (array_cmd),
		.flushing  (flushing),
		.mem_load  (mem_load),
		.hit       (hit),
		.load      (load),
		.victim    (victim)
	);

	// Miss and flush sequencing toward memory
	dcache_ctrl u_ctrl (
		.CLK       (CLK),
		.nRST      (nRST),
		.cpu_req   (cpu_req),
		.halt      (halt),
		.hit       (hit),
		.victim    (victim),
		.mem_wait  (mem_wait),
		.array_cmd (array_cmd),
		.flushing  (flushing),
		.mem_req   (mem_req),
		.flushed   (flushed)
	);

endmodule

/* tb/dcache_mem_model.sv */
`timescale 1ns/1ps

module dcache_mem_model (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::mem_req_t mem_req,
	output logic                 mem_wait,
	output dcache_pkg::word_t    mem_load
);

	import dcache_pkg::*;

	localparam int MEM_WORDS = 256;

	// Word storage, byte address bits 9:2 select the word
	word_t       mem_words [MEM_WORDS];
	logic [7:0]  word_idx;
	logic        req_active;

	// Wait cycles left for the current word
	logic [1:0]  wait_left;
	logic [15:0] lfsr_q;
	logic [15:0] lfsr_step1;
	logic [15:0] lfsr_step2;

	// Galois LFSR, one step per random bit
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Power-up contents depend on every address bit
	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h0001_0003) ^ 32'h6D2B_79F5;
	endfunction

	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_words[i] = fill_word(word_t'(i) << 2);
		end
	end

	assign word_idx   = mem_req.addr[9:2];
	assign req_active = mem_req.ren || mem_req.wen;
	assign mem_wait   = req_active && (wait_left != 2'd0);
	assign mem_load   = mem_words[word_idx];

	assign lfsr_step1 = lfsr_next(lfsr_q);
	assign lfsr_step2 = lfsr_next(lfsr_step1);

	//////////////////////////////////////////////////////////////////////
	// Wait generation
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lfsr_q    <= 16'd63;
			wait_left <= 2'd1;
		end else if (req_active) begin
			if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				// Word done, draw two bits for the next one
				wait_left <= {lfsr_step1[0], lfsr_q[0]};
				lfsr_q    <= lfsr_step2;
			end
		end
	end

	// Store lands on the accepting edge
	always_ff @(posedge CLK) begin
		if (mem_req.wen && !mem_wait) begin
			mem_words[word_idx] <= mem_req.store;
		end
	end

endmodule

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

	import dcache_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int TIMEOUT   = 400;

	logic     CLK;
	logic     nRST;
	cpu_req_t cpu_req;
	logic     halt;
	logic     hit;
	word_t    load;
	logic     flushed;
	mem_req_t mem_req;
	logic     mem_wait;
	word_t    mem_load;

	// Memory as a plain flat store sees it
	word_t       shadow [MEM_WORDS];
	logic [15:0] lfsr_q = 16'd63;

	// Write-backs seen on the memory bus
	word_t wb_addr_q [$];
	word_t wb_data_q [$];

	int seq_checks = 0;
	int seq_errors = 0;
	int mon_checks = 0;
	int mon_errors = 0;

	dcache_top UUT (
		.CLK      (CLK),
		.nRST     (nRST),
		.cpu_req  (cpu_req),
		.halt     (halt),
		.hit      (hit),
		.load     (load),
		.flushed  (flushed),
		.mem_req  (mem_req),
		.mem_wait (mem_wait),
		.mem_load (mem_load)
	);

	dcache_mem_model u_mem (
		.CLK      (CLK),
		.nRST     (nRST),
		.mem_req  (mem_req),
		.mem_wait (mem_wait),
		.mem_load (mem_load)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r      = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return r;
	endfunction

	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h0001_0003) ^ 32'h6D2B_79F5;
	endfunction

	// Expected word at a byte address
	function automatic word_t ref_read(input word_t addr);
		return shadow[addr[9:2]];
	endfunction

	function automatic word_t make_addr(input int tag, input int idx, input int blk);
		return {TAG_W'(tag), IDX_W'(idx), 1'(blk), 2'b00};
	endfunction

	function automatic int total_errors();
		return seq_errors + mon_errors;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		seq_checks++;
		assert (got == exp) else begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			seq_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		seq_checks++;
		assert (cond) else begin
			$display("%s", what);
			seq_errors++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		seq_errors++;
		$display("Timed out waiting for %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	// Drive one request and hold it until hit, cycles counts edges to hit
	task automatic access(input bit wr, input word_t addr, input word_t data,
		output int cycles);
		bit done;
		done   = 1'b0;
		cycles = 0;
		@(posedge CLK);
		cpu_req <= '{ren: !wr, wen: wr, addr: addr_fields_t'(addr), store: data};
		for (int n = 0; n < TIMEOUT && !done; n++) begin
			@(posedge CLK);
			cycles++;
			done = hit;
		end
		if (!done) begin
			stop_on_timeout("hit");
		end
		cpu_req <= '0;
	endtask

	task automatic end_test(input string name, input int err_before);
		if (total_errors() == err_before) begin
			$display("test %-16s passed", name);
		end else begin
			$display("test %-16s failed, %0d errors", name, total_errors() - err_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				shadow[i] <= fill_word(word_t'(i) << 2);
			end
		end else begin
			assert (!(hit && (mem_req.ren || mem_req.wen))) else begin
				$display("hit came while a memory request was still open");
				mon_errors++;
			end
			if (hit && cpu_req.ren) begin
				mon_checks++;
				assert (load == ref_read(word_t'(cpu_req.addr))) else begin
					$display("[FAIL] load: got %h, expected %h", load,
						ref_read(word_t'(cpu_req.addr)));
					mon_errors++;
				end
			end
			// Committed store
			if (hit && cpu_req.wen) begin
				shadow[cpu_req.addr[9:2]] <= cpu_req.store;
			end
			if (mem_req.wen && !mem_wait) begin
				wb_addr_q.push_back(mem_req.addr);
				wb_data_q.push_back(mem_req.store);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int    cycles;
		int    err0;
		int    wb0;
		bit    done;
		word_t addr_a;
		cpu_req = '0;
		halt    = 1'b0;
		nRST    = 1'b0;
		repeat (8) @(posedge CLK);
		nRST <= 1'b1;

		// Miss then hit on the other word of the block
		err0 = total_errors();
		access(1'b0, make_addr(1, 0, 0), '0, cycles);
		check_true(cycles > 1, "first read of a block hit without a fill");
		access(1'b0, make_addr(1, 0, 1), '0, cycles);
		check_true(cycles == 1, "read of the filled block did not hit at once");
		end_test("read_miss_hit", err0);

		err0 = total_errors();
		access(1'b1, make_addr(1, 0, 0), rand_bits(32), cycles);
		access(1'b0, make_addr(1, 0, 0), '0, cycles);
		end_test("write_hit", err0);

		// A, B and C share index 3, A is dirty and LRU when C arrives
		err0   = total_errors();
		addr_a = make_addr(2, 3, 0);
		access(1'b1, addr_a, rand_bits(32), cycles);
		access(1'b0, make_addr(3, 3, 0), '0, cycles);
		wb0 = wb_addr_q.size();
		access(1'b0, make_addr(4, 3, 1), '0, cycles);
		check_true(wb_addr_q.size() - wb0 == 2, "eviction of A did not write two words");
		if (wb_addr_q.size() - wb0 == 2) begin
			for (int k = 0; k < 2; k++) begin
				check_word("mem_req.addr", wb_addr_q[wb0 + k], addr_a + word_t'(4 * k));
				check_word("mem_req.store", wb_data_q[wb0 + k],
					ref_read(addr_a + word_t'(4 * k)));
			end
		end
		access(1'b0, addr_a, '0, cycles);
		end_test("lru_dirty_evict", err0);

		// Read-only lines leave without a write-back
		err0 = total_errors();
		wb0  = wb_addr_q.size();
		for (int t = 5; t < 8; t++) begin
			access(1'b0, make_addr(t, 5, t & 1), '0, cycles);
		end
		check_true(wb_addr_q.size() == wb0, "clean eviction wrote to memory");
		end_test("clean_evict", err0);

		err0 = total_errors();
		for (int i = 0; i < 48; i++) begin
			access(rand_bits(1) == 32'd1,
				make_addr(8 + int'(rand_bits(2)), int'(rand_bits(2)), int'(rand_bits(1))),
				rand_bits(32), cycles);
		end
		end_test("random_mix", err0);

		// Halt, then memory must match the flat model everywhere
		err0 = total_errors();
		done = 1'b0;
		@(posedge CLK);
		halt <= 1'b1;
		for (int n = 0; n < TIMEOUT && !done; n++) begin
			@(posedge CLK);
			done = flushed;
		end
		if (!done) begin
			stop_on_timeout("flushed");
		end
		repeat (4) begin
			@(posedge CLK);
			check_true(flushed, "flushed dropped after it rose");
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_word("mem_words", u_mem.mem_words[i], shadow[i]);
		end
		end_test("flush", err0);

		$display("%0d checks, %0d errors", seq_checks + mon_checks, total_errors());
		if (total_errors() == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
